//--- pwo_accel.f
+incdir+include
source/pwo_bus_pkg.sv
source/pwo_arith_pkg.sv
source/pwo_bus_adapter.sv
source/pwo_coef_mem.sv
source/pwo_seq.sv
source/pwo_mod_alu.sv
source/pwo_top.sv
dv/pwo_tb.sv

//--- Bender.yml
package:
  name: pwo_accel

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/pwo_bus_pkg.sv
      - source/pwo_arith_pkg.sv
      - source/pwo_bus_adapter.sv
      - source/pwo_coef_mem.sv
      - source/pwo_seq.sv
      - source/pwo_mod_alu.sv
      - source/pwo_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/pwo_tb.sv

//--- dv/pwo_tb.sv
// Accelerator testbench
`default_nettype none

`include "pwo_consts.svh"

module pwo_tb;
    import pwo_bus_pkg::*;
    import pwo_arith_pkg::*;

    localparam int POLL_LIMIT = 100;   // Status reads before giving up

    logic      clk;
    logic      rst;
    logic      bus_dv;
    logic      bus_write;
    bus_addr_t bus_addr;
    bus_data_t bus_wdata;
    bus_data_t bus_rdata;
    logic      bus_hold;
    logic      bus_err;

    // Shadow banks
    int unsigned model_a [`PWO_N];
    int unsigned model_b [`PWO_N];
    int unsigned model_c [`PWO_N];

    pwo_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .bus_dv_i    (bus_dv),
        .bus_write_i (bus_write),
        .bus_addr_i  (bus_addr),
        .bus_wdata_i (bus_wdata),
        .bus_rdata_o (bus_rdata),
        .bus_hold_o  (bus_hold),
        .bus_err_o   (bus_err)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_val(input string name, input bus_data_t actual,
                             input bus_data_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            $display("test failed");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    // ============================================================
    // Bus accesses
    // ============================================================
    // One strobe cycle and an idle cycle that returns rdata
    task automatic bus_access(input logic write, input bus_addr_t addr, input bus_data_t wdata,
                              output logic hold, output logic err, output bus_data_t rdata);
        @(negedge clk);
        bus_dv    = 1'b1;
        bus_write = write;
        bus_addr  = addr;
        bus_wdata = wdata;
        #1;
        hold = bus_hold;              // Combinational and settled by mid phase
        err  = bus_err;
        @(negedge clk);
        bus_dv    = 1'b0;
        bus_write = 1'b0;
        rdata     = bus_rdata;        // Registered on the accepting edge
    endtask

    task automatic write_word(input bus_addr_t addr, input bus_data_t data);
        logic      hold;
        logic      err;
        bus_data_t rdata;
        bus_access(1'b1, addr, data, hold, err, rdata);
        check_val("bus_hold_o", hold, 0);
        check_val("bus_err_o", err, 0);
    endtask

    task automatic read_word(input bus_addr_t addr, output bus_data_t data);
        logic hold;
        logic err;
        bus_access(1'b0, addr, '0, hold, err, data);
        check_val("bus_hold_o", hold, 0);
        check_val("bus_err_o", err, 0);
    endtask

    // ============================================================
    // Reference model
    // ============================================================
    function automatic int unsigned expected_coef(input int unsigned a, input int unsigned b,
                                                  input int unsigned c, input int unsigned mode,
                                                  input bit acc, input bit zero);
        int unsigned res;
        if (zero) begin
            return 0;
        end
        case (mode)
            `PWO_MODE_ADD: res = (a + b) % `PWO_Q;
            `PWO_MODE_SUB: res = (a + `PWO_Q - b) % `PWO_Q;   // Kept non negative
            default:       res = (a * b) % `PWO_Q;
        endcase
        if (acc) begin
            res = (res + c) % `PWO_Q;
        end
        return res;
    endfunction

    task automatic apply_model(input int unsigned mode, input bit acc, input bit zero);
        for (int i = 0; i < `PWO_N; i++) begin
            model_c[i] = expected_coef(model_a[i], model_b[i], model_c[i], mode, acc, zero);
        end
    endtask

    task automatic compare_bank_c();
        bus_data_t data;
        for (int i = 0; i < `PWO_N; i++) begin
            read_word(bus_addr_t'(`PWO_BASE_C + i), data);
            check_val($sformatf("C[%0d]", i), data, model_c[i]);
        end
    endtask

    // Clear enable first so the second write is a rising edge
    task automatic start_run(input int unsigned mode, input bit acc, input bit zero);
        bus_data_t ctrl;
        ctrl = bus_data_t'(mode);
        ctrl[`PWO_CTRL_ACC_BIT]  = acc;
        ctrl[`PWO_CTRL_ZERO_BIT] = zero;
        write_word(`PWO_ADDR_CTRL, ctrl);
        write_word(`PWO_ADDR_EN, 32'h0);
        write_word(`PWO_ADDR_EN, 32'h1);
    endtask

    task automatic wait_done(input bit never_busy, output bus_data_t stat);
        int polls;
        polls = 0;
        read_word(`PWO_ADDR_STAT, stat);
        while (!stat[1]) begin             // Done sticky
            if (never_busy) begin
                check_val("status busy", stat[0], 0);
            end
            polls++;
            if (polls >= POLL_LIMIT) begin
                $display("Engine never finished, done not set after %0d status reads", polls);
                $display("test failed");
                $fatal(1, "Timeout waiting for done");
            end
            read_word(`PWO_ADDR_STAT, stat);
        end
        check_val("status busy", stat[0], 0);
    endtask

    task automatic run_and_check(input int unsigned mode, input bit acc, input bit zero);
        bus_data_t stat;
        start_run(mode, acc, zero);
        wait_done(1'b0, stat);
        check_val("status bad_mode", stat[2], 0);
        apply_model(mode, acc, zero);
        compare_bank_c();
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        bus_data_t   data;
        bus_data_t   stat;
        logic        hold;
        logic        err;
        int unsigned mode;
        bus_addr_t   bad_addr;

        void'($urandom(32'hb343));
        rst       = 1'b0;
        bus_dv    = 1'b0;
        bus_write = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        check_val("bus_rdata_o", bus_rdata, 0);

        // Fill all banks and read each word straight back
        for (int i = 0; i < `PWO_N; i++) begin
            model_a[i] = $urandom % `PWO_Q;
            model_b[i] = $urandom % `PWO_Q;
            model_c[i] = $urandom % `PWO_Q;
            write_word(bus_addr_t'(`PWO_BASE_A + i), model_a[i]);
            read_word(bus_addr_t'(`PWO_BASE_A + i), data);
            check_val($sformatf("A[%0d]", i), data, model_a[i]);
            write_word(bus_addr_t'(`PWO_BASE_B + i), model_b[i]);
            read_word(bus_addr_t'(`PWO_BASE_B + i), data);
            check_val($sformatf("B[%0d]", i), data, model_b[i]);
            write_word(bus_addr_t'(`PWO_BASE_C + i), model_c[i]);
            read_word(bus_addr_t'(`PWO_BASE_C + i), data);
            check_val($sformatf("C[%0d]", i), data, model_c[i]);
        end

        run_and_check(`PWO_MODE_ADD, 1'b0, 1'b0);
        run_and_check(`PWO_MODE_SUB, 1'b0, 1'b0);
        run_and_check(`PWO_MODE_MUL, 1'b0, 1'b0);
        repeat (3) begin
            run_and_check($urandom % 3, 1'b1, 1'b0);   // Accumulate on
        end

        // Bank accesses are held during a run but control is not
        start_run(`PWO_MODE_MUL, 1'b0, 1'b0);
        bus_access(1'b1, `PWO_BASE_A + 5, (model_a[5] + 1) % `PWO_Q, hold, err, data);
        check_val("bus_hold_o on busy write", hold, 1);
        bus_access(1'b0, `PWO_BASE_C + 7, '0, hold, err, data);
        check_val("bus_hold_o on busy read", hold, 1);
        write_word(`PWO_ADDR_CTRL, `PWO_MODE_SUB);      // Run keeps its captured mode
        wait_done(1'b0, stat);
        apply_model(`PWO_MODE_MUL, 1'b0, 1'b0);
        compare_bank_c();
        read_word(`PWO_BASE_A + 5, data);
        check_val("A[5] after held write", data, model_a[5]);

        // Enable rewritten without a clear starts no new run
        write_word(`PWO_ADDR_EN, 32'h1);
        repeat (8) begin
            read_word(`PWO_ADDR_STAT, stat);
            check_val("status busy", stat[0], 0);
            check_val("status done", stat[1], 1);
        end
        compare_bank_c();

        // Unmapped addresses
        repeat (4) begin
            bad_addr = bus_addr_t'(`PWO_ADDR_STAT + 1 + ($urandom % (255 - `PWO_ADDR_STAT)));
            bus_access(1'b1, bad_addr, $urandom, hold, err, data);
            check_val("bus_err_o on unmapped write", err, 1);
            check_val("bus_hold_o on unmapped write", hold, 0);
            bus_access(1'b0, bad_addr, '0, hold, err, data);
            check_val("bus_err_o on unmapped read", err, 1);
        end

        // Invalid mode sets done at once and busy stays low
        start_run(3 + ($urandom % 5), 1'b0, 1'b0);
        wait_done(1'b1, stat);
        check_val("status bad_mode", stat[2], 1);
        repeat (4) begin
            read_word(`PWO_ADDR_STAT, stat);
            check_val("status busy", stat[0], 0);
        end
        compare_bank_c();

        // Zeroize beats mode and accumulate and clears bad mode
        mode = $urandom % 3;
        run_and_check(mode, 1'($urandom % 2), 1'b1);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/pwo_top.sv
// Pointwise polynomial accelerator
`default_nettype none

`include "pwo_consts.svh"

module pwo_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   bus_dv_i,
    input  logic                   bus_write_i,
    input  pwo_bus_pkg::bus_addr_t bus_addr_i,
    input  pwo_bus_pkg::bus_data_t bus_wdata_i,
    output pwo_bus_pkg::bus_data_t bus_rdata_o,
    output logic                   bus_hold_o,
    output logic                   bus_err_o
);
    import pwo_bus_pkg::*;
    import pwo_arith_pkg::*;

    // Adapter to memory
    logic      mem_en;
    logic      mem_we;
    bus_addr_t mem_addr;
    bus_data_t mem_wdata;
    bus_data_t mem_rdata;
    bus_data_t ctrl_word;
    bus_data_t en_word;

    // Adapter to sequencer
    logic      start;
    mode_t     mode;
    logic      accumulate;
    logic      zeroize;
    logic      busy;
    logic      done;
    logic      bad_mode;

    // Engine pipeline
    logic      rd_en;
    coef_idx_t rd_idx;
    coef_t     rd_a;
    coef_t     rd_b;
    coef_t     rd_c;
    logic      op_valid;
    coef_idx_t op_idx;
    mode_t     op_mode;
    logic      op_acc;
    logic      op_zero;
    logic      wr_en;
    coef_idx_t wr_idx;
    coef_t     wr_data;

    // ============================================================
    // Bus side
    // ============================================================
    pwo_bus_adapter i_adapter (
        .clk          (clk),
        .rst          (rst),
        .dv_i         (bus_dv_i),
        .write_i      (bus_write_i),
        .addr_i       (bus_addr_i),
        .wdata_i      (bus_wdata_i),
        .rdata_o      (bus_rdata_o),
        .hold_o       (bus_hold_o),
        .err_o        (bus_err_o),
        .busy_i       (busy),
        .ctrl_word_i  (ctrl_word),
        .en_word_i    (en_word),
        .mem_en_o     (mem_en),
        .mem_we_o     (mem_we),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_rdata_i  (mem_rdata),
        .start_o      (start),
        .mode_o       (mode),
        .accumulate_o (accumulate),
        .zeroize_o    (zeroize)
    );

    pwo_coef_mem i_mem (
        .clk         (clk),
        .rst         (rst),
        .bus_en_i    (mem_en),
        .bus_we_i    (mem_we),
        .bus_addr_i  (mem_addr),
        .bus_wdata_i (mem_wdata),
        .bus_rdata_o (mem_rdata),
        .rd_en_i     (rd_en),
        .rd_idx_i    (rd_idx),
        .rd_a_o      (rd_a),
        .rd_b_o      (rd_b),
        .rd_c_o      (rd_c),
        .wr_en_i     (wr_en),
        .wr_idx_i    (wr_idx),
        .wr_data_i   (wr_data),
        .busy_i      (busy),
        .done_i      (done),
        .start_i     (start),
        .bad_mode_i  (bad_mode),
        .ctrl_word_o (ctrl_word),
        .en_word_o   (en_word)
    );

    // ============================================================
    // Engine, read then compute then write back
    // ============================================================
    pwo_seq i_seq (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start),
        .mode_i       (mode),
        .accumulate_i (accumulate),
        .zeroize_i    (zeroize),
        .busy_o       (busy),
        .done_o       (done),
        .bad_mode_o   (bad_mode),
        .rd_en_o      (rd_en),
        .rd_idx_o     (rd_idx),
        .op_valid_o   (op_valid),
        .op_idx_o     (op_idx),
        .op_mode_o    (op_mode),
        .op_acc_o     (op_acc),
        .op_zero_o    (op_zero)
    );

    pwo_mod_alu i_alu (
        .clk        (clk),
        .rst        (rst),
        .op_valid_i (op_valid),
        .op_idx_i   (op_idx),
        .op_mode_i  (op_mode),
        .op_acc_i   (op_acc),
        .op_zero_i  (op_zero),
        .a_i        (rd_a),
        .b_i        (rd_b),
        .c_i        (rd_c),
        .wr_en_o    (wr_en),
        .wr_idx_o   (wr_idx),
        .wr_data_o  (wr_data)
    );

endmodule

`default_nettype wire

//--- source/pwo_mod_alu.sv
// Two stage modular ALU
`default_nettype none

`include "pwo_consts.svh"

module pwo_mod_alu (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     op_valid_i,
    input  pwo_arith_pkg::coef_idx_t op_idx_i,
    input  pwo_arith_pkg::mode_t     op_mode_i,
    input  logic                     op_acc_i,
    input  logic                     op_zero_i,
    input  pwo_arith_pkg::coef_t     a_i,
    input  pwo_arith_pkg::coef_t     b_i,
    input  pwo_arith_pkg::coef_t     c_i,
    // Write back into C
    output logic                     wr_en_o,
    output pwo_arith_pkg::coef_idx_t wr_idx_o,
    output pwo_arith_pkg::coef_t     wr_data_o
);
    import pwo_arith_pkg::*;

    localparam int RAW_W = 2 * `PWO_COEF_W;  // Full product width

    logic [RAW_W-1:0]       raw_d;
    logic [RAW_W-1:0]       raw_q;
    logic                   s1_valid_q;
    coef_idx_t              s1_idx_q;
    coef_t                  s1_c_q;
    logic                   s1_acc_q;
    logic                   s1_zero_q;
    logic [RAW_W-1:0]       red_full;
    coef_t                  res;
    logic [`PWO_COEF_W:0]   acc_sum;        // One bit of headroom
    coef_t                  acc_res;

    // ============================================================
    // Stage one, raw result
    // ============================================================
    always_comb begin
        case (op_mode_i)
            `PWO_MODE_ADD: raw_d = RAW_W'(a_i) + RAW_W'(b_i);
            `PWO_MODE_SUB: raw_d = RAW_W'(a_i) + RAW_W'(`PWO_Q) - RAW_W'(b_i); // Stays positive
            `PWO_MODE_MUL: raw_d = RAW_W'(a_i) * RAW_W'(b_i);
            default:       raw_d = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid_q <= 1'b0;
            wr_en_o    <= 1'b0;
        end else begin
            s1_valid_q <= op_valid_i;
            wr_en_o    <= s1_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        raw_q     <= raw_d;
        s1_idx_q  <= op_idx_i;
        s1_c_q    <= c_i;         // Old C for accumulate
        s1_acc_q  <= op_acc_i;
        s1_zero_q <= op_zero_i;
    end

    // ============================================================
    // Stage two, reduce and accumulate
    // ============================================================
    always_comb begin
        red_full = raw_q % RAW_W'(`PWO_Q);
        res      = coef_t'(red_full);
        acc_sum  = {1'b0, res} + {1'b0, s1_c_q};
        // Both terms below q, one subtraction is enough
        if (acc_sum >= (`PWO_COEF_W+1)'(`PWO_Q)) begin
            acc_res = coef_t'(acc_sum - (`PWO_COEF_W+1)'(`PWO_Q));
        end else begin
            acc_res = coef_t'(acc_sum);
        end
    end

    always_ff @(posedge clk) begin
        wr_idx_o <= s1_idx_q;
        if (s1_zero_q) begin
            wr_data_o <= '0;      // Zeroize wins over everything
        end else if (s1_acc_q) begin
            wr_data_o <= acc_res;
        end else begin
            wr_data_o <= res;
        end
    end

endmodule

`default_nettype wire

//--- source/pwo_seq.sv
// Run sequencer
`default_nettype none

`include "pwo_consts.svh"

module pwo_seq (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start_i,
    input  pwo_arith_pkg::mode_t     mode_i,
    input  logic                     accumulate_i,
    input  logic                     zeroize_i,
    output logic                     busy_o,
    output logic                     done_o,
    output logic                     bad_mode_o,
    // Memory read request
    output logic                     rd_en_o,
    output pwo_arith_pkg::coef_idx_t rd_idx_o,
    // ALU launch, aligned with memory data
    output logic                     op_valid_o,
    output pwo_arith_pkg::coef_idx_t op_idx_o,
    output pwo_arith_pkg::mode_t     op_mode_o,
    output logic                     op_acc_o,
    output logic                     op_zero_o
);
    import pwo_arith_pkg::*;

    seq_state_t state_q;
    coef_idx_t  cnt_q;    // Index in RUN, drain count in DRAIN
    logic       mode_ok;

    always_comb begin
        mode_ok    = (mode_i == mode_t'(`PWO_MODE_ADD)) ||
                     (mode_i == mode_t'(`PWO_MODE_SUB)) ||
                     (mode_i == mode_t'(`PWO_MODE_MUL));
        bad_mode_o = start_i && !mode_ok;
        busy_o     = state_q != SEQ_IDLE;
        rd_en_o    = state_q == SEQ_RUN;
        rd_idx_o   = cnt_q;
    end

    // ============================================================
    // FSM
    // ============================================================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q    <= SEQ_IDLE;
            cnt_q      <= '0;
            done_o     <= 1'b0;
            op_valid_o <= 1'b0;
            op_mode_o  <= '0;
            op_acc_o   <= 1'b0;
            op_zero_o  <= 1'b0;
        end else begin
            done_o     <= 1'b0;
            op_valid_o <= rd_en_o;              // Memory data arrives next cycle
            case (state_q)
                SEQ_IDLE: begin
                    if (start_i && mode_ok) begin
                        state_q   <= SEQ_RUN;
                        cnt_q     <= '0;
                        op_mode_o <= mode_i;    // Frozen for the whole run
                        op_acc_o  <= accumulate_i;
                        op_zero_o <= zeroize_i;
                    end else if (start_i) begin
                        done_o <= 1'b1;         // Bad mode ends at once
                    end
                end
                SEQ_RUN: begin
                    cnt_q <= cnt_q + 1'b1;      // Wraps to 0 for the drain
                    if (cnt_q == coef_idx_t'(`PWO_N - 1)) begin
                        state_q <= SEQ_DRAIN;
                    end
                end
                SEQ_DRAIN: begin
                    cnt_q <= cnt_q + 1'b1;
                    // Memory stage plus ALU stages, last write in the final cycle
                    if (cnt_q == coef_idx_t'(`PWO_ALU_LAT)) begin
                        state_q <= SEQ_IDLE;
                        cnt_q   <= '0;
                        done_o  <= 1'b1;
                    end
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    // Index follows the memory stage
    always_ff @(posedge clk) begin
        op_idx_o <= cnt_q;
    end

endmodule

`default_nettype wire

//--- source/pwo_coef_mem.sv
// Coefficient banks and register slots
`default_nettype none

`include "pwo_consts.svh"

module pwo_coef_mem (
    input  logic                     clk,
    input  logic                     rst,
    // Bus port
    input  logic                     bus_en_i,
    input  logic                     bus_we_i,
    input  pwo_bus_pkg::bus_addr_t   bus_addr_i,
    input  pwo_bus_pkg::bus_data_t   bus_wdata_i,
    output pwo_bus_pkg::bus_data_t   bus_rdata_o,
    // Engine read port, all three banks at one index
    input  logic                     rd_en_i,
    input  pwo_arith_pkg::coef_idx_t rd_idx_i,
    output pwo_arith_pkg::coef_t     rd_a_o,
    output pwo_arith_pkg::coef_t     rd_b_o,
    output pwo_arith_pkg::coef_t     rd_c_o,
    // Engine write port into C
    input  logic                     wr_en_i,
    input  pwo_arith_pkg::coef_idx_t wr_idx_i,
    input  pwo_arith_pkg::coef_t     wr_data_i,
    // Status sources
    input  logic                     busy_i,
    input  logic                     done_i,
    input  logic                     start_i,
    input  logic                     bad_mode_i,
    output pwo_bus_pkg::bus_data_t   ctrl_word_o,
    output pwo_bus_pkg::bus_data_t   en_word_o
);
    import pwo_bus_pkg::*;
    import pwo_arith_pkg::*;

    coef_t     bank_a [`PWO_N];
    coef_t     bank_b [`PWO_N];
    coef_t     bank_c [`PWO_N];
    bus_data_t ctrl_q;
    bus_data_t en_q;
    logic      done_sticky;
    logic      bad_sticky;
    coef_idx_t bus_idx;
    logic      a_hit;
    logic      b_hit;
    logic      c_hit;
    bus_data_t rd_word;

    // Bases are N aligned so the low bits give the index
    always_comb begin
        bus_idx = coef_idx_t'(bus_addr_i - bus_addr_t'(`PWO_BASE_A));
        a_hit   = bus_addr_i < bus_addr_t'(`PWO_BASE_B);
        b_hit   = !a_hit && (bus_addr_i < bus_addr_t'(`PWO_BASE_C));
        c_hit   = !a_hit && !b_hit && (bus_addr_i < bus_addr_t'(`PWO_ADDR_CTRL));
    end

    // Bus read mux
    always_comb begin
        rd_word = '0;
        if (a_hit) begin
            rd_word = bus_data_t'(bank_a[bus_idx]);
        end else if (b_hit) begin
            rd_word = bus_data_t'(bank_b[bus_idx]);
        end else if (c_hit) begin
            rd_word = bus_data_t'(bank_c[bus_idx]);
        end else begin
            case (bus_addr_i)
                `PWO_ADDR_CTRL: rd_word = ctrl_q;
                `PWO_ADDR_EN:   rd_word = en_q;
                `PWO_ADDR_STAT: rd_word = bus_data_t'({bad_sticky, done_sticky, busy_i});
                default:        rd_word = '0;
            endcase
        end
    end

    // ============================================================
    // Storage
    // ============================================================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `PWO_N; i++) begin
                bank_a[i] <= '0;
                bank_b[i] <= '0;
                bank_c[i] <= '0;
            end
            ctrl_q      <= '0;
            en_q        <= '0;
            done_sticky <= 1'b0;
            bad_sticky  <= 1'b0;
            bus_rdata_o <= '0;
        end else begin
            if (bus_en_i && bus_we_i) begin
                if (a_hit) bank_a[bus_idx] <= coef_t'(bus_wdata_i[`PWO_COEF_W-1:0]);
                if (b_hit) bank_b[bus_idx] <= coef_t'(bus_wdata_i[`PWO_COEF_W-1:0]);
                if (c_hit) bank_c[bus_idx] <= coef_t'(bus_wdata_i[`PWO_COEF_W-1:0]);
                if (bus_addr_i == bus_addr_t'(`PWO_ADDR_CTRL)) ctrl_q <= bus_wdata_i;
                if (bus_addr_i == bus_addr_t'(`PWO_ADDR_EN)) en_q <= bus_wdata_i;
            end
            if (bus_en_i && !bus_we_i) begin
                bus_rdata_o <= rd_word;  // Held until the next read
            end
            if (wr_en_i) begin
                bank_c[wr_idx_i] <= wr_data_i;  // Never collides, bus is held
            end
            // Sticky status
            if (start_i) begin
                done_sticky <= 1'b0;
                bad_sticky  <= bad_mode_i;
            end
            if (done_i) begin
                done_sticky <= 1'b1;
            end
        end
    end

    // Engine read, one cycle latency
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_a_o <= bank_a[rd_idx_i];
            rd_b_o <= bank_b[rd_idx_i];
            rd_c_o <= bank_c[rd_idx_i];
        end
    end

    assign ctrl_word_o = ctrl_q;
    assign en_word_o   = en_q;

endmodule

`default_nettype wire

//--- source/pwo_bus_adapter.sv
// Bus to memory adapter
`default_nettype none

`include "pwo_consts.svh"

module pwo_bus_adapter (
    input  logic                   clk,
    input  logic                   rst,
    // CPU bus
    input  logic                   dv_i,
    input  logic                   write_i,
    input  pwo_bus_pkg::bus_addr_t addr_i,
    input  pwo_bus_pkg::bus_data_t wdata_i,
    output pwo_bus_pkg::bus_data_t rdata_o,
    output logic                   hold_o,
    output logic                   err_o,
    // Engine state
    input  logic                   busy_i,
    input  pwo_bus_pkg::bus_data_t ctrl_word_i,
    input  pwo_bus_pkg::bus_data_t en_word_i,
    // Memory strobes
    output logic                   mem_en_o,
    output logic                   mem_we_o,
    output pwo_bus_pkg::bus_addr_t mem_addr_o,
    output pwo_bus_pkg::bus_data_t mem_wdata_o,
    input  pwo_bus_pkg::bus_data_t mem_rdata_i,
    // Trigger and control fields
    output logic                   start_o,
    output pwo_arith_pkg::mode_t   mode_o,
    output logic                   accumulate_o,
    output logic                   zeroize_o
);
    import pwo_bus_pkg::*;
    import pwo_arith_pkg::*;

    logic is_bank;     // A, B or C
    logic is_reg;      // Control, enable, status
    logic is_unmapped;
    logic en_bit;
    logic en_bit_q;    // Last cycle's enable bit 0

    // ============================================================
    // Address classes
    // ============================================================
    always_comb begin
        is_bank     = addr_i < bus_addr_t'(`PWO_ADDR_CTRL);
        is_reg      = !is_bank && (addr_i <= bus_addr_t'(`PWO_ADDR_STAT));
        is_unmapped = !is_bank && !is_reg;
    end

    // Banks are locked while the engine runs, registers never are
    always_comb begin
        hold_o      = dv_i & is_bank & busy_i;     // CPU repeats the access
        err_o       = dv_i & is_unmapped;
        mem_en_o    = dv_i & (is_reg | (is_bank & ~busy_i));
        mem_we_o    = mem_en_o & write_i;
        mem_addr_o  = addr_i;
        mem_wdata_o = wdata_i;
        rdata_o     = mem_rdata_i;                 // Registered in memory
    end

    // ============================================================
    // Start trigger and control fields
    // ============================================================
    always_comb begin
        en_bit       = en_word_i[0];
        start_o      = en_bit & ~en_bit_q;         // Rising edge only
        mode_o       = mode_t'(ctrl_word_i[`PWO_MODE_W-1:0]);
        accumulate_o = ctrl_word_i[`PWO_CTRL_ACC_BIT];
        zeroize_o    = ctrl_word_i[`PWO_CTRL_ZERO_BIT];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            en_bit_q <= 1'b0;
        end else begin
            en_bit_q <= en_bit;
        end
    end

endmodule

`default_nettype wire

//--- source/pwo_arith_pkg.sv
// Coefficient arithmetic types
`default_nettype none

`include "pwo_consts.svh"

package pwo_arith_pkg;

    typedef logic [`PWO_COEF_W-1:0] coef_t;     // Always below q in memory
    typedef logic [`PWO_IDX_W-1:0]  coef_idx_t; // Bank index
    typedef logic [`PWO_MODE_W-1:0] mode_t;     // Operation code

    // Sequencer FSM
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RUN,   // One index per cycle
        SEQ_DRAIN  // Memory and ALU stages emptying
    } seq_state_t;

endpackage

`default_nettype wire

//--- source/pwo_bus_pkg.sv
// CPU bus types
`default_nettype none

`include "pwo_consts.svh"

package pwo_bus_pkg;

    typedef logic [`PWO_BUS_AW-1:0] bus_addr_t; // Word address
    typedef logic [`PWO_BUS_DW-1:0] bus_data_t; // One coefficient or register per word

endpackage

`default_nettype wire

//--- include/pwo_consts.svh
// Polynomial engine constants
`ifndef PWO_CONSTS_SVH
`define PWO_CONSTS_SVH

// ============================================================
// Arithmetic
// ============================================================
`define PWO_Q          3329 // Modulus
`define PWO_N          64   // Coefficients per bank
`define PWO_COEF_W     12
`define PWO_IDX_W      6
`define PWO_MODE_W     3    // Mode field, control bits 2..0
`define PWO_ALU_LAT    2    // ALU pipeline depth

// ============================================================
// Bus and address map (word addresses)
// ============================================================
`define PWO_BUS_AW     8
`define PWO_BUS_DW     32
`define PWO_BASE_A     0
`define PWO_BASE_B     64
`define PWO_BASE_C     128
`define PWO_ADDR_CTRL  192
`define PWO_ADDR_EN    193
`define PWO_ADDR_STAT  194  // Read only, above is unmapped

// Control word fields
`define PWO_CTRL_ACC_BIT   3
`define PWO_CTRL_ZERO_BIT  4
`define PWO_MODE_ADD   0
`define PWO_MODE_SUB   1
`define PWO_MODE_MUL   2    // 3..7 invalid

`endif
